/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_sap -f src.f --Mdir obj_dir -o tb_sap_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sap_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi
exit 1

/* sap_accumulator_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module sap_accumulator_unit (
    input  logic                       clk,
    input  logic                       rst,
    output logic [sap_pkg::data_w-1:0] out_data,
    sap_bus_if.acc                     bus
);

    logic [sap_pkg::data_w-1:0] acc;
    logic [sap_pkg::data_w-1:0] imm;         // Zero-extended operand.
    logic [sap_pkg::data_w-1:0] alu_result;

    assign imm = {{(sap_pkg::data_w - sap_pkg::addr_w){1'b0}}, bus.ir_operand};

    always_comb begin
        unique case (bus.cw.acc_op)
            sap_pkg::alu_pass_imm: alu_result = imm;
            sap_pkg::alu_add:      alu_result = acc + bus.mem_rdata;  // Wraps at 12 bits.
            sap_pkg::alu_sub:      alu_result = acc - bus.mem_rdata;
            sap_pkg::alu_and:      alu_result = acc & bus.mem_rdata;
            sap_pkg::alu_or:       alu_result = acc | bus.mem_rdata;
            sap_pkg::alu_xor:      alu_result = acc ^ bus.mem_rdata;
            default:               alu_result = bus.mem_rdata;        // lda.
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (bus.cw.acc_load) begin
            acc <= alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.cw.out_load) begin
            out_data <= acc;  // Held through the handshake.
        end
    end

    assign bus.acc_value = acc;
    assign bus.acc_zero  = (acc == '0);
    assign bus.acc_neg   = acc[sap_pkg::data_w-1];  // Sign bit.

endmodule

`default_nettype wire

/* sap_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module sap_assertions (
    input logic                       clk,
    input logic                       rst,
    input logic                       start,
    input logic                       prog_ready,
    input logic                       out_valid,
    input logic                       out_ready,
    input logic [sap_pkg::data_w-1:0] out_data,
    input logic                       halted
);

    int   fail_count = 0;  // Failed assertions so far.
    logic started;         // A start was accepted since reset.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            started <= 1'b0;
        end else if (start && prog_ready) begin
            started <= 1'b1;
        end
    end

    out_hold_a: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
        fail_count++;
        $error("out_valid dropped or out_data moved before out_ready");
    end

    load_closed_a: assert property (@(posedge clk) disable iff (rst)
        started && !halted |-> !prog_ready)
    else begin
        fail_count++;
        $error("prog_ready high while a program runs");
    end

    reset_state_a: assert property (@(posedge clk)
        $fell(rst) |-> !out_valid && !halted)
    else begin
        fail_count++;
        $error("out_valid or halted high after reset");
    end

    halt_after_out_a: assert property (@(posedge clk) disable iff (rst)
        $rose(halted) |-> !out_valid)
    else begin
        fail_count++;
        $error("halted rose with an output still pending");
    end

endmodule

bind sap_top sap_assertions assertions_inst (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .prog_ready (prog_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .halted     (halted)
);

`default_nettype wire

/* sap_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface sap_bus_if;

    sap_pkg::ctrl_word_t          cw;          // Control bits for this cycle.
    logic [sap_pkg::addr_w-1:0]   pc_value;
    logic [sap_pkg::addr_w-1:0]   ir_operand;  // Low byte of IR.
    logic [sap_pkg::data_w-1:0]   mem_rdata;   // Word at MAR.
    logic [sap_pkg::data_w-1:0]   acc_value;
    logic                         acc_zero;
    logic                         acc_neg;

    modport ctrl (output cw, output ir_operand, input mem_rdata, input acc_zero,
                  input acc_neg);
    modport pc   (input cw, input ir_operand, output pc_value);
    modport mem  (input cw, input pc_value, input ir_operand, input acc_value,
                  output mem_rdata);
    modport acc  (input cw, input mem_rdata, input ir_operand, output acc_value,
                  output acc_zero, output acc_neg);

endinterface

`default_nettype wire

/* sap_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module sap_controller (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    prog_valid,
    output logic    prog_ready,
    output logic    out_valid,
    input  logic    out_ready,
    output logic    halted,
    sap_bus_if.ctrl bus
);

    sap_pkg::state_e            state;
    sap_pkg::state_e            state_next;
    logic [sap_pkg::data_w-1:0] ir;
    sap_pkg::opcode_e           opcode;
    sap_pkg::alu_op_e           alu_op;

    assign opcode         = sap_pkg::opcode_e'(ir[sap_pkg::data_w-1 -: sap_pkg::opc_w]);
    assign bus.ir_operand = ir[sap_pkg::addr_w-1:0];
    assign prog_ready     = (state == sap_pkg::st_idle);  // Loading only while idle.

    always_comb begin
        unique case (opcode)
            sap_pkg::op_add: alu_op = sap_pkg::alu_add;
            sap_pkg::op_sub: alu_op = sap_pkg::alu_sub;
            sap_pkg::op_and: alu_op = sap_pkg::alu_and;
            sap_pkg::op_or:  alu_op = sap_pkg::alu_or;
            sap_pkg::op_xor: alu_op = sap_pkg::alu_xor;
            default:         alu_op = sap_pkg::alu_pass_mem;  // lda.
        endcase
    end

    always_comb begin
        bus.cw     = '0;
        state_next = state;
        unique case (state)
            sap_pkg::st_idle: begin
                bus.cw.prog_write = prog_valid && prog_ready;  // Load handshake.
                if (start) begin
                    bus.cw.pc_clear = 1'b1;  // Run from address 0.
                    state_next      = sap_pkg::st_fetch_addr;
                end
            end
            sap_pkg::st_fetch_addr: begin
                bus.cw.mar_load = 1'b1;
                state_next      = sap_pkg::st_fetch_instr;
            end
            sap_pkg::st_fetch_instr: begin
                bus.cw.pc_inc = 1'b1;
                state_next    = sap_pkg::st_execute;
            end
            sap_pkg::st_execute: begin
                state_next = sap_pkg::st_fetch_addr;
                case (opcode)
                    sap_pkg::op_ldi: begin
                        bus.cw.acc_load = 1'b1;
                        bus.cw.acc_op   = sap_pkg::alu_pass_imm;
                    end
                    sap_pkg::op_jmp: bus.cw.pc_load = 1'b1;
                    sap_pkg::op_jz:  bus.cw.pc_load = bus.acc_zero;
                    sap_pkg::op_jn:  bus.cw.pc_load = bus.acc_neg;
                    sap_pkg::op_call: begin
                        bus.cw.pc_load = 1'b1;
                        bus.cw.pc_push = 1'b1;  // PC already points past the call.
                    end
                    sap_pkg::op_ret: bus.cw.pc_pop = 1'b1;
                    sap_pkg::op_out: begin
                        bus.cw.out_load = 1'b1;
                        state_next      = sap_pkg::st_out_wait;
                    end
                    sap_pkg::op_hlt: state_next = sap_pkg::st_idle;
                    sap_pkg::op_lda, sap_pkg::op_sta, sap_pkg::op_add, sap_pkg::op_sub,
                    sap_pkg::op_and, sap_pkg::op_or, sap_pkg::op_xor: begin
                        bus.cw.mar_load    = 1'b1;  // Operand address.
                        bus.cw.mar_from_ir = 1'b1;
                        state_next         = sap_pkg::st_mem_access;
                    end
                    default: ;  // nop.
                endcase
            end
            sap_pkg::st_mem_access: begin
                state_next = sap_pkg::st_fetch_addr;
                if (opcode == sap_pkg::op_sta) begin
                    bus.cw.ram_write = 1'b1;
                end else begin
                    bus.cw.acc_load = 1'b1;
                    bus.cw.acc_op   = alu_op;
                end
            end
            sap_pkg::st_out_wait: begin
                if (out_ready) begin
                    state_next = sap_pkg::st_fetch_addr;  // Value taken.
                end
            end
            default: state_next = sap_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= sap_pkg::st_idle;
            ir        <= '0;
            out_valid <= 1'b0;
            halted    <= 1'b0;
        end else begin
            state <= state_next;
            if (state == sap_pkg::st_fetch_instr) begin
                ir <= bus.mem_rdata;
            end
            if (bus.cw.out_load) begin
                out_valid <= 1'b1;  // Data lands in the same edge.
            end else if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (bus.cw.pc_clear) begin
                halted <= 1'b0;  // Start accepted.
            end else if (state == sap_pkg::st_execute && opcode == sap_pkg::op_hlt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* sap_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module sap_memory (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [sap_pkg::addr_w-1:0] prog_addr,
    input  logic [sap_pkg::data_w-1:0] prog_data,
    sap_bus_if.mem                     bus
);

    localparam int depth = 1 << sap_pkg::addr_w;  // 256 words.

    logic [sap_pkg::addr_w-1:0] mar;
    logic [sap_pkg::data_w-1:0] ram [depth];

    assign bus.mem_rdata = ram[mar];  // Asynchronous read.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mar <= '0;
        end else if (bus.cw.mar_load) begin
            mar <= bus.cw.mar_from_ir ? bus.ir_operand : bus.pc_value;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.cw.prog_write) begin
            ram[prog_addr] <= prog_data;  // Only while idle.
        end else if (bus.cw.ram_write) begin
            ram[mar] <= bus.acc_value;    // sta.
        end
    end

endmodule

`default_nettype wire

/* sap_pkg.sv */
`default_nettype none

package sap_pkg;

    localparam int data_w = 12;  // Data and instruction word.
    localparam int addr_w = 8;   // RAM address and operand field.
    localparam int opc_w  = 4;   // Opcode field above the operand.

    typedef enum logic [opc_w-1:0] {
        op_nop  = 4'h0,  // No operation.
        op_lda  = 4'h1,  // Acc from memory.
        op_ldi  = 4'h2,  // Acc from zero-extended immediate.
        op_sta  = 4'h3,  // Memory from acc.
        op_add  = 4'h4,
        op_sub  = 4'h5,
        op_and  = 4'h6,
        op_or   = 4'h7,
        op_xor  = 4'h8,
        op_jmp  = 4'h9,  // Unconditional jump.
        op_jz   = 4'ha,  // Jump on acc zero.
        op_jn   = 4'hb,  // Jump on acc bit 11.
        op_call = 4'hc,  // Push return address, then jump.
        op_ret  = 4'hd,  // Pop return address.
        op_out  = 4'he,  // Acc to output port.
        op_hlt  = 4'hf   // Stop and go idle.
    } opcode_e;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch_addr,   // MAR from PC.
        st_fetch_instr,  // IR from RAM, PC incremented.
        st_execute,
        st_mem_access,   // Operand read or store.
        st_out_wait      // Held until output handshake.
    } state_e;

    typedef enum logic [2:0] {
        alu_pass_mem,
        alu_pass_imm,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_e;

    typedef struct packed {
        logic    pc_inc;
        logic    pc_load;      // Jump target from operand.
        logic    pc_push;      // Save return address with pc_load.
        logic    pc_pop;
        logic    pc_clear;     // Restart at address 0.
        logic    mar_load;
        logic    mar_from_ir;  // Else from PC.
        logic    ram_write;    // Run-time store of acc.
        logic    prog_write;   // External program load.
        logic    acc_load;
        alu_op_e acc_op;
        logic    out_load;
    } ctrl_word_t;

endpackage

`default_nettype wire

/* sap_program_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module sap_program_counter #(
    parameter int STACK_DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst,
    sap_bus_if.pc bus
);

    localparam int ptr_w = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;
    localparam int cnt_w = $clog2(STACK_DEPTH + 1);

    logic [sap_pkg::addr_w-1:0] pc;
    logic [sap_pkg::addr_w-1:0] stack [STACK_DEPTH];  // Circular return stack.
    logic [ptr_w-1:0]           top;                  // Most recent entry.
    logic [ptr_w-1:0]           top_up;
    logic [ptr_w-1:0]           top_down;
    logic [cnt_w-1:0]           count;                // Live entries.

    assign bus.pc_value = pc;
    assign top_up       = (top == ptr_w'(STACK_DEPTH - 1)) ? '0 : top + 1'b1;
    assign top_down     = (top == '0) ? ptr_w'(STACK_DEPTH - 1) : top - 1'b1;

    always_ff @(posedge clk) begin
        if (bus.cw.pc_push) begin
            stack[top_up] <= pc;  // Oldest entry lost when full.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc    <= '0;
            top   <= '0;
            count <= '0;
        end else if (bus.cw.pc_clear) begin
            pc    <= '0;
            top   <= '0;
            count <= '0;
        end else if (bus.cw.pc_load) begin
            pc <= bus.ir_operand;
            if (bus.cw.pc_push) begin
                top <= top_up;
                if (count != cnt_w'(STACK_DEPTH)) begin
                    count <= count + 1'b1;  // Saturates at depth.
                end
            end
        end else if (bus.cw.pc_pop) begin
            if (count == '0) begin
                pc <= '0;  // Empty stack returns to 0.
            end else begin
                pc    <= stack[top];
                top   <= top_down;
                count <= count - 1'b1;
            end
        end else if (bus.cw.pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* sap_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sap_top #(
    parameter int STACK_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       prog_valid,
    output logic                       prog_ready,
    input  logic [sap_pkg::addr_w-1:0] prog_addr,
    input  logic [sap_pkg::data_w-1:0] prog_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [sap_pkg::data_w-1:0] out_data,
    output logic                       halted
);

    sap_bus_if bus ();  // Controller to datapath links.

    sap_controller ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .prog_valid (prog_valid),
        .prog_ready (prog_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .halted     (halted),
        .bus        (bus.ctrl)
    );

    sap_program_counter #(
        .STACK_DEPTH (STACK_DEPTH)
    ) pc_inst (
        .clk (clk),
        .rst (rst),
        .bus (bus.pc)
    );

    sap_memory mem_inst (
        .clk       (clk),
        .rst       (rst),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .bus       (bus.mem)
    );

    sap_accumulator_unit acc_inst (
        .clk      (clk),
        .rst      (rst),
        .out_data (out_data),
        .bus      (bus.acc)
    );

endmodule

`default_nettype wire

/* src.f */
sap_pkg.sv
sap_bus_if.sv
sap_controller.sv
sap_program_counter.sv
sap_memory.sv
sap_accumulator_unit.sv
sap_top.sv
sap_assertions.sv
tb_clk_gen.sv
tb_sap.sv

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int half_period  = 10;  // 20 ns clock.
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst = 1'b0;  // Released just after an edge.
    end

endmodule

`default_nettype wire

/* tb_sap.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sap;

    localparam int stack_depth   = 2;     // Third nested call wraps the stack.
    localparam int program_len   = 72;
    localparam int ready_limit   = 50;
    localparam int out_gap_limit = 200;   // Cycles between transfers.
    localparam int run_limit     = 4000;
    localparam int model_limit   = 2000;  // Model instruction budget.

    // Main code at 00, subroutines from 2c, data from 41.
    localparam logic [11:0] program_words [program_len] = '{
        12'h147, 12'ha07, 12'h277, 12'he00, 12'h200, 12'h347, 12'hf00, 12'h141,  // Flag test.
        12'he00, 12'h2c3, 12'he00, 12'h141, 12'h442, 12'he00, 12'h643, 12'he00,  // lda, ldi, add.
        12'h744, 12'he00, 12'h843, 12'he00, 12'h200, 12'h545, 12'he00, 12'h203,  // Underflow.
        12'h346, 12'he00, 12'h545, 12'h346, 12'hbff, 12'ha1f, 12'h919, 12'h146,  // Countdown.
        12'he00, 12'h545, 12'hb25, 12'h2bb, 12'he00, 12'he00, 12'hc2c, 12'he00,  // jn skip.
        12'h201, 12'h347, 12'hc34, 12'hf00, 12'h211, 12'he00, 12'hc31, 12'he00,  // Set flag.
        12'hd00, 12'h222, 12'he00, 12'hd00, 12'h250, 12'he00, 12'hc39, 12'he00,
        12'hd00, 12'h258, 12'he00, 12'hc3e, 12'he00, 12'hd00, 12'h260, 12'he00,  // Deep chain.
        12'hd00, 12'ha5c, 12'h900, 12'h0f5, 12'h3f0, 12'h001, 12'h000, 12'h000   // Data.
    };

    logic        clk;
    logic        rst;
    logic        start;
    logic        prog_valid;
    logic        prog_ready;
    logic [7:0]  prog_addr;
    logic [11:0] prog_data;
    logic        out_valid;
    logic        out_ready;
    logic [11:0] out_data;
    logic        halted;

    logic [11:0] image [256];            // Words sent through the load port.
    logic [11:0] mdl_mem [256];          // Model RAM, kept across runs.
    logic [11:0] mdl_acc;
    logic [7:0]  mdl_stack [stack_depth];
    int          stk_top;
    int          stk_count;
    logic [11:0] expected [$];
    logic [11:0] got [$];
    logic [11:0] first_got [$];
    integer      seed;
    int          errors;
    int          run;
    int          i;

    tb_clk_gen clk_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    sap_top #(
        .STACK_DEPTH (stack_depth)
    ) sap_top_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .prog_valid (prog_valid),
        .prog_ready (prog_ready),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .halted     (halted)
    );

    task automatic fail_timeout(input string what);
        $display("Timeout: %s within its cycle limit", what);
        $display("Simulation FAILED");
        $finish;
    endtask

    function automatic void build_image();
        int a;
        for (a = 0; a < 256; a++) begin
            image[a]   = (a < program_len) ? program_words[a] : {4'h0, 8'(a)};  // nop fill.
            mdl_mem[a] = image[a];
        end
    endfunction

    // Instruction-level model of the ISA; fills the expected queue.
    task automatic model_run();
        logic [7:0]  pc;
        logic [7:0]  opd;
        logic [11:0] word;
        int          steps;
        bit          running;
        pc        = 8'h00;
        stk_top   = 0;  // Start clears the return stack.
        stk_count = 0;
        steps     = 0;
        running   = 1'b1;
        while (running && steps < model_limit) begin
            word = mdl_mem[pc];
            opd  = word[7:0];
            pc   = pc + 8'd1;
            steps++;
            case (word[11:8])
                sap_pkg::op_lda: mdl_acc = mdl_mem[opd];
                sap_pkg::op_ldi: mdl_acc = {4'h0, opd};
                sap_pkg::op_sta: mdl_mem[opd] = mdl_acc;
                sap_pkg::op_add: mdl_acc = mdl_acc + mdl_mem[opd];  // Mod 4096.
                sap_pkg::op_sub: mdl_acc = mdl_acc - mdl_mem[opd];
                sap_pkg::op_and: mdl_acc = mdl_acc & mdl_mem[opd];
                sap_pkg::op_or:  mdl_acc = mdl_acc | mdl_mem[opd];
                sap_pkg::op_xor: mdl_acc = mdl_acc ^ mdl_mem[opd];
                sap_pkg::op_jmp: pc = opd;
                sap_pkg::op_jz:  pc = (mdl_acc == 12'h000) ? opd : pc;
                sap_pkg::op_jn:  pc = mdl_acc[11] ? opd : pc;
                sap_pkg::op_call: begin
                    stk_top            = (stk_top + 1) % stack_depth;
                    mdl_stack[stk_top] = pc;  // Full stack drops its oldest entry.
                    stk_count          = (stk_count < stack_depth) ? stk_count + 1 : stk_count;
                    pc                 = opd;
                end
                sap_pkg::op_ret: begin
                    if (stk_count == 0) begin
                        pc = 8'h00;  // Empty stack.
                    end else begin
                        pc        = mdl_stack[stk_top];
                        stk_top   = (stk_top + stack_depth - 1) % stack_depth;
                        stk_count = stk_count - 1;
                    end
                end
                sap_pkg::op_out: expected.push_back(mdl_acc);
                sap_pkg::op_hlt: running = 1'b0;
                default: ;
            endcase
        end
        assert (!running) else begin
            errors++;
            $display("Reference model never reached hlt");
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!prog_ready) begin
            cycles++;
            if (cycles > ready_limit) fail_timeout("prog_ready did not rise");
            @(posedge clk);
            #2;
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0) begin
            cycles++;
            if (cycles > ready_limit) fail_timeout("reset was not released");
            @(posedge clk);
            #2;
        end
    endtask

    task automatic load_image();
        int a;
        for (a = 0; a < 256; a++) begin
            wait_ready();
            prog_valid = 1'b1;
            prog_addr  = 8'(a);
            prog_data  = image[a];
            @(posedge clk);
            #2;
        end
        prog_valid = 1'b0;
    endtask

    task automatic take_output(input logic [11:0] value);
        logic [11:0] exp;
        got.push_back(value);
        assert (expected.size() != 0) else begin
            errors++;
            $display("ERR %0t: output %h with none expected", $time, value);
        end
        if (expected.size() != 0) begin
            exp = expected.pop_front();
            assert (value == exp) else begin
                errors++;
                $display("ERR %0t: output %0d is %h, expected %h", $time, got.size(), value, exp);
            end
        end
    endtask

    // Start pulse, then collect transfers under random back-pressure until halt.
    task automatic run_program();
        int cycles;
        int quiet;
        wait_ready();
        start = 1'b1;
        @(posedge clk);
        #2;
        start  = 1'b0;
        cycles = 0;
        quiet  = 0;
        while (!halted) begin
            out_ready = (($random(seed) & 3) != 0);
            if (out_valid && out_ready) begin
                take_output(out_data);  // Transfers on the next edge.
                quiet = 0;
            end else begin
                quiet++;
            end
            if (quiet > out_gap_limit) fail_timeout("out_valid transfer did not come");
            cycles++;
            if (cycles > run_limit) fail_timeout("halted did not rise");
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        seed       = 58;
        errors     = 0;
        mdl_acc    = 12'h000;  // Accumulator is cleared only by reset.
        start      = 1'b0;
        prog_valid = 1'b0;
        prog_addr  = 8'h00;
        prog_data  = 12'h000;
        out_ready  = 1'b0;
        build_image();
        wait_reset_release();
        assert (prog_ready && !out_valid && !halted) else begin
            errors++;
            $display("ERR %0t: idle outputs wrong after reset", $time);
        end
        load_image();
        for (run = 1; run <= 2; run++) begin
            model_run();
            run_program();
            assert (expected.size() == 0) else begin
                errors++;
                $display("ERR %0t: %0d expected outputs never came", $time, expected.size());
            end
            assert (halted && prog_ready) else begin
                errors++;
                $display("ERR %0t: halted or prog_ready low after hlt", $time);
            end
            if (run == 1) begin
                first_got = got;
            end else begin
                assert (got.size() == first_got.size()) else begin
                    errors++;
                    $display("ERR %0t: restart gave %0d outputs, first run %0d", $time,
                             got.size(), first_got.size());
                end
                for (i = 0; i < got.size() && i < first_got.size(); i++) begin
                    assert (got[i] == first_got[i]) else begin
                        errors++;
                        $display("ERR %0t: restart output %0d is %h, first run %h", $time, i,
                                 got[i], first_got[i]);
                    end
                end
            end
            expected.delete();
            got.delete();
        end
        $display("Error count: testbench checks %0d, protocol assertions %0d", errors,
                 sap_top_inst.assertions_inst.fail_count);
        if (errors == 0 && sap_top_inst.assertions_inst.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
